/* all.f */
+incdir+source
source/cdc_pkg.sv
source/cdc_sync.sv
source/cdc_main_clock.sv
source/cdc_pg_clock.sv
source/clock_domain_controller.sv
tests/tb_clock_domain_controller.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_clock_domain_controller \
    -f all.f -Mdir obj_dir -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Result: FAIL"; exit 1; }
echo "Result: PASS"
exit 0

/* source/cdc_config.svh */
`ifndef CDC_CONFIG_SVH
`define CDC_CONFIG_SVH

// --------------------
// Timer sizing
// --------------------

// Width of the idle and holdoff counters
// Holdoff exponents stay at or below 15 so 2^n still fits
`define CDC_ITBITS 16

// --------------------
// Domain defaults
// --------------------

// Number of async gated-clock requesters
`define CDC_AREQ 2

// 1 = domain leaves reset with the clock running and clkreq high
// 0 = domain leaves reset gated and locked
`define CDC_DEF_PWRON 1

`endif

/* source/cdc_main_clock.sv */
`timescale 1ns/100ps

`include "cdc_config.svh"

module cdc_main_clock #(
    parameter int AREQ = `CDC_AREQ
) (
    input  logic                   clock,            // Domain clock
    input  logic                   rst_n,
    input  logic                   reset_b,          // Domain reset, async
    input  cdc_pkg::cdc_cfg_t      cfg,
    input  logic                   gclock_req_sync,  // Request synchronous to clock
    input  logic [AREQ-1:0]        gclock_req_async, // Glitch-free async requests
    input  cdc_pkg::ism_state_t    ism_agent,
    input  cdc_pkg::pg_to_main_t   from_pg,          // Already in clock domain
    input  logic                   pok_sync,

    output logic                   reset_sync_b,
    output logic                   greset_b,
    output logic                   gclock,
    output logic                   gclock_active,
    output logic [AREQ-1:0]        gclock_ack_async,
    output logic                   ism_locked,
    output logic                   boundary_locked,
    output logic                   pok,
    output cdc_pkg::main_to_pg_t   to_pg
);

    import cdc_pkg::*;

    localparam int ITBITS    = `CDC_ITBITS;
    localparam bit DEF_PWRON = `CDC_DEF_PWRON;

    logic [1:0]        rst_sync_q;       // Reset deassertion pipe
    logic              req_async_or;     // Raw OR of async requests
    logic              req_or_sync;
    logic              quiet;
    logic              wake_req;
    logic [ITBITS-1:0] idle_limit;
    logic [ITBITS-1:0] idle_cnt;
    main_state_t       state;
    logic              gate_en_q;        // Flopped clock-gate enable
    logic              gate_en_lat;      // Latched while clock low
    logic              gclock_active_q;
    logic              locked_q;
    logic              hold_q;           // Asking pgcb half to keep clkreq
    logic              ism_wake_q;

    // --------------------
    // Reset and POK
    // --------------------

    // Assert async, release after two clock edges
    always_ff @(posedge clock or negedge reset_b) begin
        if (!reset_b) begin
            rst_sync_q <= '0;
        end else begin
            rst_sync_q <= {rst_sync_q[0], 1'b1};
        end
    end

    assign reset_sync_b = rst_sync_q[1];
    assign pok          = pok_sync;
    assign greset_b     = reset_sync_b & pok_sync;   // Held while power is not ok

    // --------------------
    // Request detection
    // --------------------

    assign req_async_or = |gclock_req_async;

    cdc_sync #(
        .WIDTH (1)
    ) req_sync_i (
        .clk   (clock),
        .rst_n (rst_n),
        .d     (req_async_or),
        .q     (req_or_sync)
    );

    // Domain is quiet only with no request of any kind and the ISM parked
    assign quiet    = !gclock_req_sync && !req_or_sync && (ism_agent == ISM_IDLE);
    assign wake_req = !quiet || hold_q;   // Hold keeps a short request alive

    assign idle_limit = ITBITS'(1) << cfg.clkgate_holdoff;

    // --------------------
    // Gating FSM
    // --------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state           <= DEF_PWRON ? MAIN_RUNNING : MAIN_GATED;
            idle_cnt        <= '0;
            gate_en_q       <= DEF_PWRON;
            gclock_active_q <= DEF_PWRON;
            locked_q        <= !DEF_PWRON;
            hold_q          <= 1'b0;
            ism_wake_q      <= 1'b0;
        end else begin
            case (state)
                MAIN_RUNNING: begin
                    // Clock is back once pgcb half reports ack
                    if (from_pg.assert_clkreq) begin
                        hold_q <= 1'b0;
                    end
                    if (!quiet || hold_q || cfg.clkgate_disabled) begin
                        idle_cnt <= '0;                  // Any activity restarts the wait
                    end else if (idle_cnt == idle_limit - 1'b1) begin
                        idle_cnt  <= '0;
                        gate_en_q <= 1'b0;               // Stop gclock at next low phase
                        state     <= MAIN_GATE_PEND;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                MAIN_GATE_PEND: begin
                    gclock_active_q <= 1'b0;
                    locked_q        <= 1'b1;
                    state           <= MAIN_GATED;
                end
                MAIN_GATED: begin
                    ism_wake_q <= (ism_agent != ISM_IDLE);
                    if (!quiet) begin
                        hold_q <= 1'b1;
                    end
                    // Reopen only once pgcb side has the clock acknowledged
                    if (wake_req && from_pg.unlock_domain) begin
                        gate_en_q <= 1'b1;
                        state     <= MAIN_UNGATE_PEND;
                    end
                end
                MAIN_UNGATE_PEND: begin
                    gclock_active_q <= 1'b1;
                    locked_q        <= 1'b0;
                    ism_wake_q      <= 1'b0;
                    state           <= MAIN_RUNNING;
                end
                default: begin
                    state <= MAIN_RUNNING;
                end
            endcase
        end
    end

    // --------------------
    // Clock gate
    // --------------------

    // Transparent while clock is low, so enable changes never clip a pulse
    always_latch begin
        if (!clock) begin
            gate_en_lat = gate_en_q;
        end
    end

    assign gclock = clock & gate_en_lat;

    assign gclock_active    = gclock_active_q;
    assign gclock_ack_async = gclock_req_async & {AREQ{gclock_active_q}};
    assign ism_locked       = locked_q;
    assign boundary_locked  = locked_q;

    // Raw async OR also goes out so pgcb half can wake with clock stopped
    assign to_pg.domain_locked = locked_q;
    assign to_pg.clkreq_hold   = hold_q | req_async_or;
    assign to_pg.ism_wake      = ism_wake_q;

    // Ungating must follow an unlock seen when the FSM left GATED
    a_unlock_before_active: assert property (
        @(posedge clock) disable iff (!rst_n)
        $rose(gclock_active_q) |-> $past(from_pg.unlock_domain, 2)
    );

    // Locks and running clock are exclusive
    a_lock_excl: assert property (
        @(posedge clock) disable iff (!rst_n)
        gclock_active_q |-> !(ism_locked || boundary_locked)
    );

endmodule

/* source/cdc_pg_clock.sv */
`timescale 1ns/100ps

`include "cdc_config.svh"

module cdc_pg_clock (
    input  logic                  pgcb_clk,            // Always-on clock
    input  logic                  rst_n,
    input  cdc_pkg::cdc_cfg_t     cfg,
    input  cdc_pkg::main_to_pg_t  from_main,           // Synchronized to pgcb_clk
    input  logic                  clkack,              // From clock source, async
    input  logic                  pwrgate_disabled,
    input  logic                  pwrgate_pmc_wake,
    input  logic                  pgcb_pwrgate_active, // Power gating underway

    output logic                  clkreq,
    output logic                  pwrgate_ready,
    output cdc_pkg::pg_to_main_t  to_main
);

    import cdc_pkg::*;

    localparam int ITBITS    = `CDC_ITBITS;
    localparam bit DEF_PWRON = `CDC_DEF_PWRON;

    pg_state_t         state;
    logic [ITBITS-1:0] hold_cnt;        // Shared by both holdoffs
    logic [ITBITS-1:0] hold_limit;
    logic              hold_done;
    logic              wake;
    logic              clkreq_q;
    logic              ready_q;
    logic              unlock_q;
    logic              assert_q;

    // Any source that needs the domain back
    assign wake = pwrgate_pmc_wake | from_main.clkreq_hold | from_main.ism_wake;

    // Off holdoff while clkreq is on, power-gate holdoff afterwards
    assign hold_limit = (state == PG_CLKREQ_ON) ?
                        (ITBITS'(1) << cfg.clkreq_off_holdoff) :
                        (ITBITS'(1) << cfg.pwrgate_holdoff);
    assign hold_done  = (hold_cnt == hold_limit - 1'b1);

    // --------------------
    // clkreq FSM
    // --------------------

    always_ff @(posedge pgcb_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= DEF_PWRON ? PG_CLKREQ_ON : PG_CLKREQ_OFF;
            hold_cnt <= '0;
            clkreq_q <= DEF_PWRON;
            ready_q  <= 1'b0;
            unlock_q <= 1'b0;
            assert_q <= 1'b0;
        end else begin
            assert_q <= clkreq_q & clkack;     // Request granted by clock source
            case (state)
                PG_CLKREQ_ON: begin
                    unlock_q <= clkack;
                    if (!from_main.domain_locked || wake || cfg.clkreq_ctl_disabled) begin
                        hold_cnt <= '0;
                    end else if (hold_done) begin
                        hold_cnt <= '0;
                        clkreq_q <= 1'b0;     // Release the clock
                        unlock_q <= 1'b0;
                        state    <= PG_OFF_PEND;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                PG_OFF_PEND: begin
                    if (wake) begin
                        clkreq_q <= 1'b1;
                        state    <= PG_WAKE;
                    end else if (!clkack) begin
                        hold_cnt <= '0;
                        state    <= PG_CLKREQ_OFF;
                    end
                end
                PG_CLKREQ_OFF: begin
                    if (wake || !from_main.domain_locked) begin
                        clkreq_q <= 1'b1;
                        state    <= PG_WAKE;
                    end else if (pwrgate_disabled) begin
                        hold_cnt <= '0;
                    end else if (hold_done) begin
                        hold_cnt <= '0;
                        ready_q  <= 1'b1;
                        state    <= PG_READY;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                PG_READY: begin
                    // Wake withdraws ready and requests the clock together
                    if (wake || !from_main.domain_locked) begin
                        ready_q  <= 1'b0;
                        clkreq_q <= 1'b1;
                        state    <= PG_WAKE;
                    end else if (pwrgate_disabled) begin
                        ready_q <= 1'b0;
                        state   <= PG_CLKREQ_OFF;
                    end
                end
                PG_WAKE: begin
                    // Stay locked until the PGCB finishes its gating pass
                    if (clkack && !pgcb_pwrgate_active) begin
                        unlock_q <= 1'b1;
                        state    <= PG_CLKREQ_ON;
                    end
                end
                default: begin
                    state <= PG_CLKREQ_ON;
                end
            endcase
        end
    end

    assign clkreq                = clkreq_q;
    assign pwrgate_ready         = ready_q;
    assign to_main.unlock_domain = unlock_q;
    assign to_main.assert_clkreq = assert_q;

    // Ready only with the clock released
    a_ready_no_clkreq: assert property (
        @(posedge pgcb_clk) disable iff (!rst_n)
        pwrgate_ready |-> !clkreq
    );

    // Main half hold must block clkreq release
    a_hold_keeps_clkreq: assert property (
        @(posedge pgcb_clk) disable iff (!rst_n)
        $fell(clkreq) |-> !$past(from_main.clkreq_hold)
    );

endmodule

/* source/cdc_pkg.sv */
package cdc_pkg;

    // --------------------
    // State encodings
    // --------------------

    // IOSF agent ISM, only IDLE means the agent is quiet
    typedef enum logic [2:0] {
        ISM_IDLE        = 3'b000,
        ISM_IDLE_REQ    = 3'b001,
        ISM_ACTIVE_REQ  = 3'b010,
        ISM_ACTIVE      = 3'b011,
        ISM_CREDIT_REQ  = 3'b100,
        ISM_CREDIT_ACK  = 3'b101,
        ISM_CREDIT_DONE = 3'b110
    } ism_state_t;

    typedef enum logic [1:0] {
        MAIN_RUNNING     = 2'b00,   // gclock running, idle timer active
        MAIN_GATE_PEND   = 2'b01,   // Enable dropped, waiting one cycle to lock
        MAIN_GATED       = 2'b10,   // gclock stopped, ISM and boundary locked
        MAIN_UNGATE_PEND = 2'b11    // Enable raised, unlock on next cycle
    } main_state_t;

    typedef enum logic [2:0] {
        PG_CLKREQ_ON  = 3'b000,     // Clock requested
        PG_OFF_PEND   = 3'b001,     // clkreq dropped, waiting for clkack low
        PG_CLKREQ_OFF = 3'b010,     // Clock released, power-gate holdoff
        PG_READY      = 3'b011,     // pwrgate_ready asserted
        PG_WAKE       = 3'b100      // clkreq raised again, waiting for clkack
    } pg_state_t;

    // --------------------
    // Structs
    // --------------------

    // Quasi-static configuration, holdoffs are exponents (2^n clocks)
    typedef struct packed {
        logic       clkgate_disabled;
        logic       clkreq_ctl_disabled;
        logic [3:0] clkgate_holdoff;
        logic [3:0] pwrgate_holdoff;
        logic [3:0] clkreq_off_holdoff;
    } cdc_cfg_t;

    typedef struct packed {
        logic domain_locked;        // Gated and locked
        logic clkreq_hold;          // Main half needs the clock
        logic ism_wake;             // ISM left idle while gated
    } main_to_pg_t;

    typedef struct packed {
        logic unlock_domain;        // Ungate and unlock allowed
        logic assert_clkreq;        // clkreq high and acknowledged
    } pg_to_main_t;

endpackage

/* source/cdc_sync.sv */
`timescale 1ns/100ps

module cdc_sync #(
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] d,     // Quasi-static levels from the other domain
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] meta_q;       // First stage, may go metastable
    logic [WIDTH-1:0] sync_q;

    // Each bit is an independent level, so per-bit skew is harmless
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= d;
            sync_q <= meta_q;
        end
    end

    assign q = sync_q;

endmodule

/* source/clock_domain_controller.sv */
`timescale 1ns/100ps

`include "cdc_config.svh"

module clock_domain_controller #(
    parameter int AREQ = `CDC_AREQ
) (
    input  logic                clock,                // Domain clock
    input  logic                pgcb_clk,             // Always-on clock
    input  logic                rst_n,
    input  logic                reset_b,
    input  cdc_pkg::cdc_cfg_t   cfg,
    input  logic                gclock_req_sync,
    input  logic [AREQ-1:0]     gclock_req_async,
    input  cdc_pkg::ism_state_t ism_agent,
    input  logic                pgcb_pok,
    input  logic                clkack,
    input  logic                pwrgate_disabled,
    input  logic                pwrgate_pmc_wake,
    input  logic                pgcb_pwrgate_active,

    output logic                reset_sync_b,
    output logic                greset_b,
    output logic                gclock,
    output logic                gclock_active,
    output logic [AREQ-1:0]     gclock_ack_async,
    output logic                ism_locked,
    output logic                boundary_locked,
    output logic                pok,
    output logic                clkreq,
    output logic                pwrgate_ready
);

    import cdc_pkg::*;

    localparam int PG2M_W = $bits(pg_to_main_t) + 1;    // Struct plus POK

    main_to_pg_t       to_pg;
    main_to_pg_t       to_pg_sync;
    pg_to_main_t       to_main;
    pg_to_main_t       from_pg;
    logic [PG2M_W-1:0] pg2m_sync;
    logic              pok_sync;

    // --------------------
    // Crossings
    // --------------------

    // Async request OR rides in to_pg.clkreq_hold
    cdc_sync #(.WIDTH($bits(main_to_pg_t))) m2pg_sync_i (
        .clk (pgcb_clk), .rst_n (rst_n), .d (to_pg), .q (to_pg_sync)
    );

    cdc_sync #(.WIDTH(PG2M_W)) pg2m_sync_i (
        .clk (clock), .rst_n (rst_n), .d ({to_main, pgcb_pok}), .q (pg2m_sync)
    );

    assign from_pg  = pg2m_sync[PG2M_W-1:1];
    assign pok_sync = pg2m_sync[0];

    // --------------------
    // Halves
    // --------------------

    cdc_main_clock #(.AREQ(AREQ)) main_i (
        .clock, .rst_n, .reset_b, .cfg, .gclock_req_sync, .gclock_req_async,
        .ism_agent, .from_pg, .pok_sync, .reset_sync_b, .greset_b, .gclock,
        .gclock_active, .gclock_ack_async, .ism_locked, .boundary_locked, .pok,
        .to_pg
    );

    cdc_pg_clock pg_i (
        .pgcb_clk, .rst_n, .cfg, .from_main (to_pg_sync), .clkack,
        .pwrgate_disabled, .pwrgate_pmc_wake, .pgcb_pwrgate_active,
        .clkreq, .pwrgate_ready, .to_main
    );

endmodule

/* tests/tb_clock_domain_controller.sv */
`timescale 1ns/100ps

`include "cdc_config.svh"

module tb_clock_domain_controller;

    import cdc_pkg::*;

    localparam int AREQ     = `CDC_AREQ;
    localparam int SEED     = 66050;
    localparam int GATE_HO  = 3;         // clkgate_holdoff exponent
    localparam int OFF_HO   = 3;         // clkreq_off_holdoff exponent
    localparam int PWR_HO   = 3;         // pwrgate_holdoff exponent
    localparam int SYNC_CYC = 2;         // Cost of one crossing
    localparam int ACK_DLY  = 4;         // Clock source answer delay in pgcb cycles
    localparam int MAX_HOLD = 16;        // Longest random request hold
    // One full gate, release and wake pass with margin
    localparam int PASS_CYC = (1 << GATE_HO) + (1 << OFF_HO) + (1 << PWR_HO)
                              + 4 * SYNC_CYC + 2 * ACK_DLY + 8;
    localparam int LIMIT_CYC = 200 + 50 + 10 * PASS_CYC + AREQ * MAX_HOLD + 2000;

    logic            clock, pgcb_clk, rst_n, reset_b;
    cdc_cfg_t        cfg;
    logic            gclock_req_sync;
    logic [AREQ-1:0] gclock_req_async;
    ism_state_t      ism_agent;
    logic            pgcb_pok, clkack, pwrgate_disabled, pwrgate_pmc_wake;
    logic            pgcb_pwrgate_active;
    logic            reset_sync_b, greset_b, gclock, gclock_active;
    logic [AREQ-1:0] gclock_ack_async;
    logic            ism_locked, boundary_locked, pok, clkreq, pwrgate_ready;

    int          errors = 0;
    int          test_errs_start, tests_run, tests_bad;
    string       test_name;
    int          cycle_cnt = 0;
    int          gclock_edges = 0;
    realtime     t_active_fell, t_clkreq_fell;
    logic [3:0]  ack_pipe;               // Clock source delay line

    clock_domain_controller #(.AREQ(AREQ)) dut_i (
        .clock, .pgcb_clk, .rst_n, .reset_b, .cfg, .gclock_req_sync, .gclock_req_async,
        .ism_agent, .pgcb_pok, .clkack, .pwrgate_disabled, .pwrgate_pmc_wake,
        .pgcb_pwrgate_active, .reset_sync_b, .greset_b, .gclock, .gclock_active,
        .gclock_ack_async, .ism_locked, .boundary_locked, .pok, .clkreq, .pwrgate_ready
    );

    // --------------------
    // Clocks and models
    // --------------------

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        pgcb_clk = 1'b0;
        #3;                              // pgcb_clk lags clock by 3 ns
        forever #5 pgcb_clk = ~pgcb_clk;
    end

    // Clock source model returns clkreq as clkack 4 pgcb cycles later
    initial begin
        ack_pipe = '1;                   // clkreq leaves reset high
        clkack   = 1'b1;
        forever begin
            @(posedge pgcb_clk);
            #2;
            clkack   = ack_pipe[3];
            ack_pipe = {ack_pipe[2:0], clkreq};
        end
    end

    always @(posedge gclock) gclock_edges <= gclock_edges + 1;
    always @(negedge gclock_active) t_active_fell = $realtime;
    always @(negedge clkreq) t_clkreq_fell = $realtime;

    // Run limit in clock cycles
    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT_CYC) begin
            $display("Timeout: run did not finish within %0d clock cycles", LIMIT_CYC);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // --------------------
    // Helpers
    // --------------------

    task automatic step(input int n);
        repeat (n) @(posedge clock);
        #1;                              // Drive and sample just after the edge
    endtask

    task automatic pg_step();
        @(posedge pgcb_clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        test_errs_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_errs_start) begin
            $display("[%0t] %s: ok", $time, test_name);
        end else begin
            tests_bad++;
            $display("[%0t] %s: %0d errors", $time, test_name, errors - test_errs_start);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s: %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_ack(input string what, input logic [AREQ-1:0] exp,
                             input logic [AREQ-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s: %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic wait_active(input logic level, input int max_cyc, output int took);
        took = 0;
        while (gclock_active !== level && took < max_cyc) begin
            step(1);
            took++;
        end
        if (gclock_active !== level)
            note_error($sformatf("gclock_active not %b after %0d cycles", level, max_cyc));
    endtask

    task automatic wait_clkreq(input logic level, input int max_cyc, output int took);
        took = 0;
        while (clkreq !== level && took < max_cyc) begin
            pg_step();
            took++;
        end
        if (clkreq !== level)
            note_error($sformatf("clkreq not %b after %0d pgcb cycles", level, max_cyc));
    endtask

    task automatic wait_ready(input logic level, input int max_cyc, output int took);
        took = 0;
        while (pwrgate_ready !== level && took < max_cyc) begin
            pg_step();
            took++;
        end
        if (pwrgate_ready !== level)
            note_error($sformatf("pwrgate_ready not %b after %0d pgcb cycles", level, max_cyc));
    endtask

    // Wait until the domain is gated, the clock released and power-gate ready
    task automatic wait_gated_ready();
        int took;
        wait_active(1'b0, PASS_CYC, took);
        wait_ready(1'b1, PASS_CYC, took);
        step(1);
    endtask

    // --------------------
    // Tests
    // --------------------

    task automatic reset_values();
        int took;
        begin_test("reset_values");
        check_bit("clkreq", 1'b1, clkreq);
        check_bit("gclock_active", 1'b1, gclock_active);
        check_bit("pwrgate_ready", 1'b0, pwrgate_ready);
        check_bit("ism_locked", 1'b0, ism_locked);
        check_bit("boundary_locked", 1'b0, boundary_locked);
        check_bit("greset_b in domain reset", 1'b0, greset_b);
        check_bit("reset_sync_b in domain reset", 1'b0, reset_sync_b);
        step(SYNC_CYC);                  // POK crosses in
        reset_b = 1'b1;
        took    = 0;
        while (!greset_b && took < 3) begin
            step(1);
            took++;
        end
        check_bit("greset_b 3 cycles after reset_b", 1'b1, greset_b);
        check_bit("reset_sync_b 3 cycles after reset_b", 1'b1, reset_sync_b);
        check_bit("pok", 1'b1, pok);
        end_test();
    endtask

    task automatic idle_gating();
        int took;
        int edges;
        begin_test("idle_gating");
        for (int i = 0; i < 200; i++) begin
            step(1);
            if (!gclock_active) begin
                note_error("gated with clkgate_disabled set");
                break;
            end
        end
        cfg.clkgate_disabled = 1'b0;
        took = 0;
        while (gclock_active && took < (1 << GATE_HO) + 4) begin
            step(1);
            took++;
        end
        if (gclock_active)
            note_error("gclock_active did not fall after the idle holdoff");
        else if (took <= (1 << GATE_HO))
            note_error($sformatf("gclock_active fell after only %0d cycles", took));
        check_bit("ism_locked", 1'b1, ism_locked);
        check_bit("boundary_locked", 1'b1, boundary_locked);
        edges = gclock_edges;
        step(20);
        if (gclock_edges != edges)
            note_error("gclock kept toggling while gated");
        end_test();
    endtask

    task automatic release_and_ready();
        int  took;
        real dt;
        begin_test("release_and_ready");
        wait_clkreq(1'b0, PASS_CYC, took);
        dt = t_clkreq_fell - t_active_fell;
        if (dt <= 0.0 || dt > real'(((1 << OFF_HO) + SYNC_CYC + 2) * 10))
            note_error($sformatf("clkreq fell %0.1f ns after gating", dt));
        // Held off while power gating is disabled
        for (int i = 0; i < 50; i++) begin
            pg_step();
            if (pwrgate_ready) begin
                note_error("pwrgate_ready rose with pwrgate_disabled set");
                break;
            end
        end
        step(1);
        pwrgate_disabled = 1'b0;
        took = 0;
        while (!pwrgate_ready && took < (1 << PWR_HO) + 4) begin
            pg_step();
            took++;
            if (pwrgate_ready && clkack)
                note_error("pwrgate_ready rose while clkack high");
        end
        check_bit("pwrgate_ready", 1'b1, pwrgate_ready);
        if (took < (1 << PWR_HO))
            note_error($sformatf("pwrgate_ready rose after only %0d pgcb cycles", took));
        check_bit("clkreq with ready", 1'b0, clkreq);
        step(1);
        end_test();
    endtask

    task automatic wake_by_request();
        int              took;
        int              hold;
        logic [AREQ-1:0] req;
        begin_test("wake_by_request");
        for (int i = 0; i < AREQ; i++) begin
            req    = '0;
            req[i] = 1'b1;
            hold   = 1 + int'($urandom % MAX_HOLD);
            gclock_req_async = req;
            wait_clkreq(1'b1, SYNC_CYC + 3, took);
            check_bit("pwrgate_ready on wake", 1'b0, pwrgate_ready);
            took = 0;
            while (!gclock_active && took < PASS_CYC) begin
                step(1);
                took++;
                if (!gclock_active)
                    check_ack("ack while gated", '0, gclock_ack_async);
            end
            if (!gclock_active)
                note_error($sformatf("requester %0d never ungated the domain", i));
            check_ack("ack once active", req, gclock_ack_async);
            check_bit("boundary_locked", 1'b0, boundary_locked);
            repeat (hold) begin
                step(1);
                check_ack("ack during hold", req, gclock_ack_async);
            end
            gclock_req_async = '0;
            step(1);
            check_ack("ack after request drop", '0, gclock_ack_async);
            wait_gated_ready();
        end
        end_test();
    endtask

    task automatic wake_by_pmc_and_ism();
        int took;
        begin_test("wake_by_pmc_and_ism");
        check_bit("pwrgate_ready before PMC wake", 1'b1, pwrgate_ready);
        pwrgate_pmc_wake = 1'b1;
        pg_step();                       // Sampling edge
        check_bit("pwrgate_ready after PMC wake", 1'b0, pwrgate_ready);
        check_bit("clkreq after PMC wake", 1'b1, clkreq);
        step(1);
        pwrgate_pmc_wake = 1'b0;
        check_bit("ism_locked stays set", 1'b1, ism_locked);
        wait_gated_ready();
        // ISM leaves idle while gated
        ism_agent = ISM_ACTIVE_REQ;
        wait_clkreq(1'b1, SYNC_CYC + 3, took);
        check_bit("pwrgate_ready on ISM wake", 1'b0, pwrgate_ready);
        step(1);
        wait_active(1'b1, PASS_CYC, took);
        check_bit("boundary_locked", 1'b0, boundary_locked);
        check_bit("ism_locked", 1'b0, ism_locked);
        step(4);
        ism_agent = ISM_IDLE;
        wait_active(1'b0, PASS_CYC, took);   // Quiet again so the domain gates once more
        end_test();
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        void'($urandom(SEED));
        rst_n                   = 1'b0;
        reset_b                 = 1'b0;
        cfg.clkgate_disabled    = 1'b1;
        cfg.clkreq_ctl_disabled = 1'b0;
        cfg.clkgate_holdoff     = 4'(GATE_HO);
        cfg.pwrgate_holdoff     = 4'(PWR_HO);
        cfg.clkreq_off_holdoff  = 4'(OFF_HO);
        gclock_req_sync         = 1'b0;
        gclock_req_async        = '0;
        ism_agent               = ISM_IDLE;
        pgcb_pok                = 1'b1;
        pwrgate_disabled        = 1'b1;
        pwrgate_pmc_wake        = 1'b0;
        pgcb_pwrgate_active     = 1'b0;
        tests_run               = 0;
        tests_bad               = 0;
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;

        reset_values();
        idle_gating();
        release_and_ready();
        wake_by_request();
        wake_by_pmc_and_ism();

        $display("Tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
